/* Bender.yml */
package:
  name: rv_core

export_include_dirs:
  - design

sources:
  - design/rv_pkg.sv
  - design/rv_inst_rom.sv
  - design/rv_reg_file.sv
  - design/rv_decoder.sv
  - design/rv_alu.sv
  - design/rv_data_ram.sv
  - design/rv_core.sv
  - target: test
    files:
      - verif/rv_core_tb.sv

/* design/rv_alu.sv */
`timescale 1ns/1ps
`include "rv_config.svh"

module rv_alu import rv_pkg::*; (
    input  logic [`RV_XLEN-1:0] a,
    input  logic [`RV_XLEN-1:0] b,
    input  alu_op_e             op,
    output logic [`RV_XLEN-1:0] y
);

    logic [4:0] sh;
    logic       lt_s;
    logic       lt_u;

    assign sh   = b[4:0];                         // Shift amount
    assign lt_s = $signed(a) < $signed(b);
    assign lt_u = a < b;

    always_comb begin
        case (op)
            ADD:     y = a + b;
            SUB:     y = a - b;
            SLL:     y = a << sh;
            SLT:     y = {{(`RV_XLEN-1){1'b0}}, lt_s};
            SLTU:    y = {{(`RV_XLEN-1){1'b0}}, lt_u};
            XOR:     y = a ^ b;
            SRL:     y = a >> sh;
            SRA:     y = $unsigned($signed(a) >>> sh);  // Sign fill
            OR:      y = a | b;
            AND:     y = a & b;
            default: y = '0;                      // Unused encodings
        endcase
    end

endmodule

/* design/rv_config.svh */
`ifndef RV_CONFIG_SVH
`define RV_CONFIG_SVH

// Core data path width
`define RV_XLEN 32

// Instruction memory depth in 32-bit words
`define RV_IMEM_WORDS 256

// Data memory depth in 32-bit words
`define RV_DMEM_WORDS 256

// First fetch address after reset
`define RV_RESET_PC 32'h0000_0000

// Both memories are indexed by word, so the byte offset bits are never used
// for addressing. Depths must stay powers of two so that out-of-range
// addresses wrap by simple truncation.

`endif

/* design/rv_core.sv */
`timescale 1ns/1ps
`include "rv_config.svh"

module rv_core import rv_pkg::*; (
    input  logic      CLK,
    input  logic      RST,
    input  logic      run,
    input  load_cmd_t load,
    output retire_t   retire
);

    logic [`RV_XLEN-1:0] pc;
    logic [31:0]         instr;
    ctrl_t               ctrl;
    logic [`RV_XLEN-1:0] rs1_data;
    logic [`RV_XLEN-1:0] rs2_data;
    logic [`RV_XLEN-1:0] alu_b;
    logic [`RV_XLEN-1:0] alu_y;
    logic [`RV_XLEN-1:0] ram_rdata;
    logic [`RV_XLEN-1:0] wb_data;
    logic                rf_wen;
    logic                ram_wen;
    retire_t             retire_d;

    always_ff @(posedge CLK) begin
        if (RST) begin
            pc <= `RV_RESET_PC;
        end else if (run) begin
            pc <= pc + 32'd4;
        end
    end

    rv_inst_rom i_rv_inst_rom (.CLK(CLK), .load(load), .pc(pc), .instr(instr));

    rv_decoder i_rv_decoder (.instr(instr), .ctrl(ctrl));

    rv_reg_file i_rv_reg_file (
        .CLK(CLK), .RST(RST),
        .rs1(ctrl.rs1), .rs2(ctrl.rs2), .rd(ctrl.rd),
        .wen(rf_wen), .wdata(wb_data),
        .rdata1(rs1_data), .rdata2(rs2_data)
    );

    assign alu_b = ctrl.use_imm ? ctrl.imm : rs2_data;

    rv_alu i_rv_alu (.a(rs1_data), .b(alu_b), .op(ctrl.alu_op), .y(alu_y));

    rv_data_ram i_rv_data_ram (
        .CLK(CLK), .addr(alu_y), .wen(ram_wen), .wdata(rs2_data), .rdata(ram_rdata)
    );

    // Nothing commits while the core is paused
    assign rf_wen  = run && ctrl.reg_write && (ctrl.rd != 5'd0);
    assign ram_wen = run && ctrl.mem_write;
    assign wb_data = ctrl.mem_read ? ram_rdata : alu_y;

    always_comb begin
        retire_d           = '0;
        retire_d.valid     = run;
        retire_d.pc        = pc;
        retire_d.instr     = instr;
        retire_d.rd        = ctrl.rd;
        retire_d.wdata     = ctrl.mem_write ? rs2_data : wb_data;
        retire_d.wen       = rf_wen;
        retire_d.mem_write = ram_wen;
        retire_d.illegal   = ctrl.illegal;
    end

    always_ff @(posedge CLK) begin
        if (RST) begin
            retire.valid <= 1'b0;
        end else begin
            retire <= retire_d;                   // One cycle behind execute
        end
    end

endmodule

/* design/rv_data_ram.sv */
`timescale 1ns/1ps
`include "rv_config.svh"

module rv_data_ram (
    input  logic                CLK,
    input  logic [`RV_XLEN-1:0] addr,
    input  logic                wen,
    input  logic [`RV_XLEN-1:0] wdata,
    output logic [`RV_XLEN-1:0] rdata
);

    localparam int IDX_W = $clog2(`RV_DMEM_WORDS);

    logic [`RV_XLEN-1:0] mem [`RV_DMEM_WORDS];
    logic [IDX_W-1:0]    idx;

    // Byte address to word index, wraps at the depth
    assign idx = addr[IDX_W+1:2];

    always_ff @(posedge CLK) begin
        if (wen) begin
            mem[idx] <= wdata;
        end
    end

    assign rdata = mem[idx];                      // Read before write

endmodule

/* design/rv_decoder.sv */
`timescale 1ns/1ps
`include "rv_config.svh"

module rv_decoder import rv_pkg::*; (
    input  logic [31:0] instr,
    output ctrl_t       ctrl
);

    opcode_e             opcode;
    funct3_e             funct3;
    logic [6:0]          funct7;
    logic [`RV_XLEN-1:0] imm_i;
    logic [`RV_XLEN-1:0] imm_s;
    logic [`RV_XLEN-1:0] shamt;
    logic                bad;

    assign opcode = opcode_e'(instr[6:0]);
    assign funct3 = funct3_e'(instr[14:12]);
    assign funct7 = instr[31:25];
    assign imm_i  = {{20{instr[31]}}, instr[31:20]};
    assign imm_s  = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign shamt  = {27'd0, instr[24:20]};

    always_comb begin
        ctrl        = '0;
        ctrl.rs1    = instr[19:15];
        ctrl.rs2    = instr[24:20];
        ctrl.rd     = instr[11:7];
        ctrl.alu_op = ADD;
        bad         = 1'b0;
        case (opcode)
            OP_REG: begin
                ctrl.reg_write = 1'b1;
                case (funct3)
                    F3_ADD:  ctrl.alu_op = funct7[5] ? SUB : ADD;
                    F3_SLL:  ctrl.alu_op = SLL;
                    F3_SLT:  ctrl.alu_op = SLT;
                    F3_SLTU: ctrl.alu_op = SLTU;
                    F3_XOR:  ctrl.alu_op = XOR;
                    F3_SRL:  ctrl.alu_op = funct7[5] ? SRA : SRL;
                    F3_OR:   ctrl.alu_op = OR;
                    default: ctrl.alu_op = AND;
                endcase
                // Bit 30 is only meaningful for sub and sra
                if (funct7 == 7'b0100000) begin
                    bad = !(funct3 == F3_ADD || funct3 == F3_SRL);
                end else begin
                    bad = (funct7 != 7'b0000000);
                end
            end
            OP_IMM: begin
                ctrl.reg_write = 1'b1;
                ctrl.use_imm   = 1'b1;
                ctrl.imm       = shamt;               // Overridden for addi
                case (funct3)
                    F3_ADD: ctrl.imm = imm_i;
                    F3_SLL: begin
                        ctrl.alu_op = SLL;
                        bad         = (funct7 != 7'b0000000);
                    end
                    F3_SRL: begin
                        ctrl.alu_op = funct7[5] ? SRA : SRL;
                        bad = (funct7 != 7'b0000000) && (funct7 != 7'b0100000);
                    end
                    default: bad = 1'b1;          // slti, xori etc. not built
                endcase
            end
            OP_LOAD: begin
                ctrl.reg_write = 1'b1;
                ctrl.mem_read  = 1'b1;
                ctrl.use_imm   = 1'b1;
                ctrl.imm       = imm_i;
                bad            = (instr[14:12] != 3'b010);  // lw only
            end
            OP_STORE: begin
                ctrl.mem_write = 1'b1;
                ctrl.use_imm   = 1'b1;
                ctrl.imm       = imm_s;
                bad            = (instr[14:12] != 3'b010);  // sw only
            end
            default: bad = 1'b1;
        endcase
        // Unsupported encodings retire as a no-op
        if (bad) begin
            ctrl.reg_write = 1'b0;
            ctrl.mem_read  = 1'b0;
            ctrl.mem_write = 1'b0;
            ctrl.illegal   = 1'b1;
        end
    end

endmodule

/* design/rv_inst_rom.sv */
`timescale 1ns/1ps
`include "rv_config.svh"

module rv_inst_rom import rv_pkg::*; (
    input  logic                CLK,
    input  load_cmd_t           load,
    input  logic [`RV_XLEN-1:0] pc,
    output logic [31:0]         instr
);

    localparam int IDX_W = $clog2(`RV_IMEM_WORDS);

    logic [31:0]      mem [`RV_IMEM_WORDS];
    logic [IDX_W-1:0] fetch_idx;
    logic [IDX_W-1:0] load_idx;

    // Word index, upper bits dropped so the PC wraps at the depth
    assign fetch_idx = pc[IDX_W+1:2];
    assign load_idx  = load.addr[IDX_W-1:0];

    // Program loader, one word per strobe
    always_ff @(posedge CLK) begin
        if (load.valid) begin
            mem[load_idx] <= load.data;
        end
    end

    assign instr = mem[fetch_idx];                // Combinational fetch

endmodule

/* design/rv_pkg.sv */
`include "rv_config.svh"

package rv_pkg;

    // Major opcodes handled by the core
    typedef enum logic [6:0] {
        OP_REG   = 7'b0110011,
        OP_IMM   = 7'b0010011,
        OP_LOAD  = 7'b0000011,
        OP_STORE = 7'b0100011
    } opcode_e;

    // ALU operations
    typedef enum logic [3:0] {
        ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND
    } alu_op_e;

    // funct3 field of OP_REG and OP_IMM
    typedef enum logic [2:0] {
        F3_ADD  = 3'b000,                         // add, sub, addi
        F3_SLL  = 3'b001,
        F3_SLT  = 3'b010,
        F3_SLTU = 3'b011,
        F3_XOR  = 3'b100,
        F3_SRL  = 3'b101,                         // srl, sra and immediates
        F3_OR   = 3'b110,
        F3_AND  = 3'b111
    } funct3_e;

    typedef struct packed {
        logic [4:0]          rs1;
        logic [4:0]          rs2;
        logic [4:0]          rd;
        alu_op_e             alu_op;
        logic                use_imm;             // B operand from imm
        logic                reg_write;
        logic                mem_read;
        logic                mem_write;
        logic                illegal;
        logic [`RV_XLEN-1:0] imm;
    } ctrl_t;

    typedef struct packed {
        logic                valid;
        logic [7:0]          addr;                // Word index
        logic [`RV_XLEN-1:0] data;
    } load_cmd_t;

    typedef struct packed {
        logic                valid;
        logic [`RV_XLEN-1:0] pc;
        logic [31:0]         instr;
        logic [4:0]          rd;
        logic [`RV_XLEN-1:0] wdata;               // Store data for sw
        logic                wen;
        logic                mem_write;
        logic                illegal;
    } retire_t;

endpackage

/* design/rv_reg_file.sv */
`timescale 1ns/1ps
`include "rv_config.svh"

module rv_reg_file (
    input  logic                CLK,
    input  logic                RST,
    input  logic [4:0]          rs1,
    input  logic [4:0]          rs2,
    input  logic [4:0]          rd,
    input  logic                wen,
    input  logic [`RV_XLEN-1:0] wdata,
    output logic [`RV_XLEN-1:0] rdata1,
    output logic [`RV_XLEN-1:0] rdata2
);

    logic [`RV_XLEN-1:0] regs [32];

    // x0 is cleared by reset and never written, so it always reads zero
    always_ff @(posedge CLK) begin
        if (RST) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && (rd != 5'd0)) begin
            regs[rd] <= wdata;
        end
    end

    // No bypass, reads see the value from before the edge
    assign rdata1 = regs[rs1];
    assign rdata2 = regs[rs2];

endmodule

/* rv_core.f */
+incdir+design
design/rv_pkg.sv
design/rv_inst_rom.sv
design/rv_reg_file.sv
design/rv_decoder.sv
design/rv_alu.sv
design/rv_data_ram.sv
design/rv_core.sv
verif/rv_core_tb.sv

/* verif/rv_core_tb.sv */
`timescale 1ns/1ps
`include "rv_config.svh"

module rv_core_tb import rv_pkg::*; ();

    localparam int PROG_LEN   = 60;
    localparam int CLK_PERIOD = 4;

    logic      CLK = 1'b0;
    logic      RST;
    logic      run;
    load_cmd_t load;
    retire_t   retire;

    logic [31:0] prog [`RV_IMEM_WORDS];
    logic [31:0] model_regs [32];
    logic [31:0] model_mem [`RV_DMEM_WORDS];
    logic [31:0] exp_pc = '0;
    int          retired = 0;
    int          errors = 0;

    logic [31:0] cur;
    logic [31:0] rs1v;
    logic [31:0] rs2v;
    logic [31:0] imm_i;
    logic [31:0] imm_s;
    logic [31:0] op_b;
    logic [31:0] alu_res;
    logic [31:0] mem_addr;
    logic [31:0] exp_wdata;
    logic        exp_wen;
    logic        exp_mw;
    logic        exp_ill;

    rv_core i_rv_core (.CLK(CLK), .RST(RST), .run(run), .load(load), .retire(retire));

    always #(CLK_PERIOD / 2) CLK = ~CLK;

    // ISA model of the instruction expected at exp_pc
    always_comb begin
        cur   = prog[exp_pc[9:2]];
        rs1v  = model_regs[cur[19:15]];
        rs2v  = model_regs[cur[24:20]];
        imm_i = {{20{cur[31]}}, cur[31:20]};
        imm_s = {{20{cur[31]}}, cur[31:25], cur[11:7]};
        op_b  = rs2v;
        if (cur[6:0] == OP_IMM) begin
            op_b = (cur[14:12] == 3'd0) ? imm_i : {27'd0, cur[24:20]};  // Shamt for shifts
        end
        case (cur[14:12])
            3'd0:    alu_res = (cur[6:0] == OP_REG && cur[30]) ? rs1v - op_b : rs1v + op_b;
            3'd1:    alu_res = rs1v << op_b[4:0];
            3'd2:    alu_res = {31'd0, $signed(rs1v) < $signed(op_b)};
            3'd3:    alu_res = {31'd0, rs1v < op_b};
            3'd4:    alu_res = rs1v ^ op_b;
            3'd5:    alu_res = cur[30] ? $unsigned($signed(rs1v) >>> op_b[4:0])
                                       : rs1v >> op_b[4:0];
            3'd6:    alu_res = rs1v | op_b;
            default: alu_res = rs1v & op_b;
        endcase
        mem_addr  = rs1v + ((cur[6:0] == OP_STORE) ? imm_s : imm_i);
        exp_mw    = (cur[6:0] == OP_STORE);
        exp_ill   = !(cur[6:0] inside {OP_REG, OP_IMM, OP_LOAD, OP_STORE});
        exp_wen   = !exp_ill && !exp_mw && (cur[11:7] != 5'd0);
        exp_wdata = alu_res;
        if (cur[6:0] == OP_LOAD) begin
            exp_wdata = model_mem[mem_addr[9:2]];
        end else if (exp_mw) begin
            exp_wdata = rs2v;                     // Store data
        end
    end

    always @(posedge CLK) begin
        if (!RST && retire.valid) begin
            if (exp_wen) begin
                model_regs[cur[11:7]] <= exp_wdata;
            end
            if (exp_mw) begin
                model_mem[mem_addr[9:2]] <= rs2v;
            end
            exp_pc  <= exp_pc + 32'd4;
            retired <= retired + 1;
        end
    end

    task automatic report_mismatch(input string name, input logic [31:0] exp_v,
                                   input logic [31:0] act_v);
        errors++;
        $display("Error %s: expected %h, actual %h", name, exp_v, act_v);
    endtask

    reset_quiet: assert property (@(posedge CLK) $past(RST) |-> !retire.valid)
        else report_mismatch("reset_quiet", 32'd0, 32'($sampled(retire.valid)));
    run_gating: assert property (@(posedge CLK) disable iff (RST) retire.valid == $past(run))
        else report_mismatch("run_gating", 32'($past(run)), 32'($sampled(retire.valid)));
    pc_order: assert property (@(posedge CLK) disable iff (RST)
            retire.valid |-> retire.pc == exp_pc)
        else report_mismatch("pc_order", $sampled(exp_pc), $sampled(retire.pc));
    instr_fetch: assert property (@(posedge CLK) disable iff (RST)
            retire.valid |-> retire.instr == cur)
        else report_mismatch("instr_fetch", $sampled(cur), $sampled(retire.instr));
    dest_reg: assert property (@(posedge CLK) disable iff (RST)
            retire.valid && !exp_mw && !exp_ill |-> retire.rd == cur[11:7])
        else report_mismatch("dest_reg", 32'($sampled(cur[11:7])), 32'($sampled(retire.rd)));
    flags: assert property (@(posedge CLK) disable iff (RST) retire.valid |->
            {retire.wen, retire.mem_write, retire.illegal} == {exp_wen, exp_mw, exp_ill})
        else report_mismatch("flags", 32'($sampled({exp_wen, exp_mw, exp_ill})),
            32'($sampled({retire.wen, retire.mem_write, retire.illegal})));
    wdata: assert property (@(posedge CLK) disable iff (RST)
            retire.valid && !exp_ill |-> retire.wdata == exp_wdata)
        else report_mismatch("wdata", $sampled(exp_wdata), $sampled(retire.wdata));

    task automatic build_program();
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        logic [2:0]  k;
        logic [11:0] imm;
        logic [7:0]  stored;
        int          sel;
        stored  = '0;
        prog[0] = {12'(4 * $urandom_range(200)), 5'd0, 3'd0, 5'd1, OP_IMM};  // Base in x1
        for (int i = 1; i < PROG_LEN; i++) begin
            rd  = 5'($urandom);
            rs1 = 5'($urandom);
            rs2 = 5'($urandom);
            f3  = 3'($urandom);
            k   = 3'($urandom);
            imm = 12'($urandom);
            if (rd == 5'd1) begin
                rd = 5'd0;                        // x1 keeps the base
            end
            sel = (i >= PROG_LEN - 2) ? 9 : ((i < 11) ? 10 : $urandom_range(9));
            if (sel inside {7, 8} && !stored[k]) begin
                sel = 6;                          // Store first, load later
            end
            case (sel)
                0, 1, 2, 3: begin
                    imm[11:5] = ((f3 == 3'd0 || f3 == 3'd5) && imm[0]) ? 7'h20 : 7'h00;
                    prog[i]   = {imm[11:5], rs2, rs1, f3, rd, OP_REG};
                end
                4, 5: begin
                    f3 = ($urandom_range(2) == 0) ? 3'd0 : (f3[0] ? 3'd1 : 3'd5);
                    if (f3 != 3'd0) begin
                        imm = {1'b0, (f3 == 3'd5) & imm[10], 5'd0, imm[4:0]};
                    end
                    prog[i] = {imm, rs1, f3, rd, OP_IMM};
                end
                6: begin
                    prog[i]   = {7'd0, rs2, 5'd1, 3'd2, k, 2'b00, OP_STORE};
                    stored[k] = 1'b1;
                end
                7, 8:    prog[i] = {7'd0, k, 2'b00, 5'd1, 3'd2, rd, OP_LOAD};
                9:       prog[i] = {25'($urandom), 7'b0001011};  // Custom-0 opcode
                default: prog[i] = {imm, 5'd0, 3'd0, rd, OP_IMM};
            endcase
        end
    endtask

    initial begin
        int split;
        int pause;
        void'($urandom(32'h67763c02));
        RST  = 1'b1;
        run  = 1'b0;
        load = '0;
        for (int r = 0; r < 32; r++) begin
            model_regs[r] = '0;
        end
        build_program();
        split = $urandom_range(PROG_LEN - 10, 10);
        pause = $urandom_range(5, 2);
        repeat (2) @(posedge CLK);
        RST <= 1'b0;
        for (int i = 0; i < PROG_LEN; i++) begin
            @(posedge CLK);
            load <= '{valid: 1'b1, addr: 8'(i), data: prog[i]};
        end
        @(posedge CLK);
        load <= '0;
        run  <= 1'b1;
        repeat (split) @(posedge CLK);
        run <= 1'b0;                              // Pause mid-program
        repeat (pause) @(posedge CLK);
        run <= 1'b1;
        repeat (PROG_LEN - split) @(posedge CLK);
        run <= 1'b0;
        wait (retired == PROG_LEN);
        @(posedge CLK);
        $display("Retired %0d of %0d instructions, %0d errors", retired, PROG_LEN, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    initial begin
        #((2 * PROG_LEN + 20) * CLK_PERIOD);
        $display("Watchdog timeout: only %0d of %0d instructions retired", retired, PROG_LEN);
        $display("ERRORS FOUND");
        $finish;
    end

endmodule
